/* source/daq_pkg.sv */
/*
  shared widths, types and constants of the capture front end
  eight channels of 16-bit samples, one 256-bit line per 16 samples
  the DRAM address is the channel index on top of a 22-bit line count
  the trigger threshold is fixed at build time
*/
package daq_pkg;

	////////////////////////////// sizes
	localparam int num_channels   = 8;       // capture channels
	localparam int ch_w           = 3;       // channel index width
	localparam int sample_w       = 16;      // one sample
	localparam int words_per_line = 16;      // samples per DRAM line
	localparam int line_w         = 256;     // one DRAM beat
	localparam int addr_w         = 25;      // DRAM word address
	localparam int line_cnt_w     = 22;      // per channel line counter

	////////////////////////////// types
	typedef logic [sample_w-1:0] sample_t;   // raw sample
	typedef logic [line_w-1:0]   line_t;     // sample 0 in bits 15:0

	// must be strictly exceeded to trigger
	localparam sample_t trigger_threshold = 16'h7000;

	// write controller states
	typedef enum logic [1:0] {
		idle,                                // search for a ready channel
		fetch,                               // take the line, load the port
		write                                // wait for the DRAM to accept
	} ctrl_state_t;

endpackage

/* source/line_buffer_if.sv */
`timescale 1ns/1ps
/*
  handshake between one channel packer and the write side
  take is a single cycle pulse and only comes while ready is high
  the held line stays stable until the cycle after take
*/
interface line_buffer_if import daq_pkg::*; ();

	logic  line_ready;    // a finished line is held
	line_t line_data;     // the held line
	logic  line_take;     // pulse, frees the holding register
	logic  line_dropped;  // sticky overflow flag

	modport packer (
		output line_ready, line_data, line_dropped,
		input  line_take
	);

	modport ctrl (
		input  line_ready,
		output line_take
	);

	modport port (input line_data);

endinterface

/* source/channel_packer.sv */
`timescale 1ns/1ps
/*
  packs one channel into 256-bit lines, sample 0 in the low bits
  one finished line is held until the write side takes it
  a line that completes while the holding register is full is lost
  and the overflow flag then stays set until reset
*/
module channel_packer import daq_pkg::*; (
	input  logic          avalon_clk,
	input  logic          rst_n,       // sync, active low
	input  logic          rx_valid,    // shared sample strobe
	input  sample_t       sample,
	line_buffer_if.packer line_buf
);

	logic [$clog2(words_per_line)-1:0] word_cnt; // words in the line being packed
	line_t line_sr;                              // packing shift register
	line_t line_next;                            // shift register after this sample
	logic  last_word;                            // this strobe closes a line
	logic  hold_busy;                            // holding reg still full next cycle

	assign line_next = {sample, line_sr[line_w-1:sample_w]}; // new word enters at the top
	assign last_word = rx_valid && (word_cnt == words_per_line - 1);
	assign hold_busy = line_buf.line_ready && !line_buf.line_take; // take frees it

	////////////////////////////// packing
	always_ff @(posedge avalon_clk) begin
		if (rx_valid) begin
			line_sr <= line_next;                // after 16 shifts sample 0 is lowest
		end
	end

	always_ff @(posedge avalon_clk) begin
		if (!rst_n) begin
			word_cnt <= '0;
		end else if (rx_valid) begin
			word_cnt <= word_cnt + 1'b1;         // wraps at the line boundary
		end
	end

	////////////////////////////// holding register
	always_ff @(posedge avalon_clk) begin
		if (last_word && !hold_busy) begin
			line_buf.line_data <= line_next;     // complete line incl. this sample
		end
	end

	always_ff @(posedge avalon_clk) begin
		if (!rst_n) begin
			line_buf.line_ready   <= 1'b0;
			line_buf.line_dropped <= 1'b0;
		end else begin
			if (last_word && hold_busy) begin
				line_buf.line_dropped <= 1'b1;   // new line discarded, sticky
			end
			if (last_word && !hold_busy) begin
				line_buf.line_ready <= 1'b1;     // refill, also in the take cycle
			end else if (line_buf.line_take) begin
				line_buf.line_ready <= 1'b0;     // line went to the write port
			end
		end
	end

endmodule

/* source/trigger_detect.sv */
`timescale 1ns/1ps
/*
  sticky trigger on the first sample above trigger_threshold
  the time stamp is the 0-based strobe index since reset, 16 bits, wraps
  only the first crossing is recorded
*/
module trigger_detect import daq_pkg::*; (
	input  logic        avalon_clk,
	input  logic        rst_n,
	input  logic        rx_valid,
	input  sample_t     samples [num_channels],
	output logic        triggering_status,
	output logic [15:0] triggering_time_stamp
);

	logic [15:0] strobe_cnt;   // strobes seen since reset
	logic        over;         // some channel above threshold

	// any channel strictly above the threshold
	always_comb begin
		over = 1'b0;
		for (int i = 0; i < num_channels; i++) begin
			if (samples[i] > trigger_threshold) begin
				over = 1'b1;
			end
		end
	end

	////////////////////////////// strobe counter
	always_ff @(posedge avalon_clk) begin
		if (!rst_n) begin
			strobe_cnt <= '0;
		end else if (rx_valid) begin
			strobe_cnt <= strobe_cnt + 1'b1;     // index of the next strobe
		end
	end

	////////////////////////////// capture
	always_ff @(posedge avalon_clk) begin
		if (!rst_n) begin
			triggering_status     <= 1'b0;
			triggering_time_stamp <= '0;
		end else if (rx_valid && over && !triggering_status) begin
			triggering_status     <= 1'b1;       // stays until reset
			triggering_time_stamp <= strobe_cnt; // index of the crossing strobe
		end
	end

endmodule

/* source/write_ctrl.sv */
`timescale 1ns/1ps
/*
  round-robin write controller over the eight channel buffers
  search starts at channel 0 after reset, then after the last grant
  one line is in the write port at a time, the next search starts after accept
*/
module write_ctrl import daq_pkg::*; (
	input  logic            avalon_clk,
	input  logic            rst_n,
	line_buffer_if.ctrl     bufs [num_channels],
	output logic            load,        // port registers line and address
	output logic [ch_w-1:0] sel,         // channel being written
	input  logic            accepted     // DRAM took the write
);

	ctrl_state_t             state;
	logic [num_channels-1:0] ready_vec;  // line_ready of all channels
	logic [ch_w-1:0]         rr_ptr;     // first channel to look at
	logic [ch_w-1:0]         grant;      // channel chosen in idle
	logic [ch_w-1:0]         cand;
	logic [ch_w-1:0]         pick;
	logic                    found;

	for (genvar i = 0; i < num_channels; i++) begin : g_ch
		assign ready_vec[i]      = bufs[i].line_ready;
		assign bufs[i].line_take = (state == fetch) && (grant == ch_w'(i)); // one cycle
	end

	////////////////////////////// round-robin search
	always_comb begin
		found = 1'b0;
		pick  = rr_ptr;
		cand  = rr_ptr;
		for (int k = 0; k < num_channels; k++) begin
			cand = rr_ptr + ch_w'(k);            // wraps over the channel index
			if (!found && ready_vec[cand]) begin
				found = 1'b1;
				pick  = cand;
			end
		end
	end

	////////////////////////////// fsm
	always_ff @(posedge avalon_clk) begin
		if (!rst_n) begin
			state  <= idle;
			rr_ptr <= '0;
			grant  <= '0;
		end else begin
			unique case (state)
				idle: begin
					if (found) begin
						grant <= pick;
						state <= fetch;
					end
				end
				fetch: begin
					rr_ptr <= grant + 1'b1;      // next search after this one
					state  <= write;
				end
				write: begin
					if (accepted) begin
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	assign load = (state == fetch);
	assign sel  = grant;

endmodule

/* source/dram_write_port.sv */
`timescale 1ns/1ps
/*
  single beat DRAM write drive, no bursts
  address is {channel, line count}, the count wraps at 22 bits per channel
  address and data hold while wait request is high
*/
module dram_write_port import daq_pkg::*; (
	input  logic              avalon_clk,
	input  logic              rst_n,
	line_buffer_if.port       bufs [num_channels],
	input  logic              load,
	input  logic [ch_w-1:0]   sel,
	output logic              accepted,
	input  logic              dram_wait_request,
	output logic [addr_w-1:0] dram_write_address,
	output line_t             dram_write_data,
	output logic              dram_write_enable
);

	line_t                 line_vec [num_channels];  // held lines of all channels
	logic [line_cnt_w-1:0] line_cnt [num_channels];  // next line per channel

	for (genvar i = 0; i < num_channels; i++) begin : g_ch
		assign line_vec[i] = bufs[i].line_data;
	end

	////////////////////////////// line select and address
	always_ff @(posedge avalon_clk) begin
		if (load) begin
			dram_write_data    <= line_vec[sel];
			dram_write_address <= {sel, line_cnt[sel]}; // channel region on top
		end
	end

	////////////////////////////// write enable and counters
	always_ff @(posedge avalon_clk) begin
		if (!rst_n) begin
			dram_write_enable <= 1'b0;
			for (int i = 0; i < num_channels; i++) begin
				line_cnt[i] <= '0;
			end
		end else begin
			if (load) begin
				dram_write_enable <= 1'b1;
				line_cnt[sel]     <= line_cnt[sel] + 1'b1; // advance after use
			end else if (accepted) begin
				dram_write_enable <= 1'b0;
			end
		end
	end

	// write completes on the first edge without wait request
	assign accepted = dram_write_enable && !dram_wait_request;

endmodule

/* source/capture_top.sv */
`timescale 1ns/1ps
/*
  eight channel capture front end writing 256-bit lines to DRAM
  all channels share one valid strobe and the avalon clock
  every write is a single beat, no read path
  overflow flags and trigger status are sticky until reset
*/
module capture_top import daq_pkg::*; (
	input  logic              avalon_clk,
	input  logic              rst_n,                 // sync, active low
	input  logic              rx_valid,              // samples of all channels valid
	input  sample_t           rx_data [num_channels],
	input  logic              dram_wait_request,
	output logic [addr_w-1:0] dram_write_address,
	output line_t             dram_write_data,
	output logic              dram_write_enable,
	output logic              triggering_status,
	output logic [15:0]       triggering_time_stamp,
	output logic [num_channels-1:0] overflow         // one per channel
);

	logic            load;       // controller to port
	logic [ch_w-1:0] sel;
	logic            accepted;   // port to controller

	line_buffer_if bufs [num_channels] ();

	////////////////////////////// channel packers
	for (genvar i = 0; i < num_channels; i++) begin : g_pack
		channel_packer packer_i (
			.avalon_clk (avalon_clk),
			.rst_n      (rst_n),
			.rx_valid   (rx_valid),
			.sample     (rx_data[i]),
			.line_buf   (bufs[i])
		);

		assign overflow[i] = bufs[i].line_dropped;
	end

	////////////////////////////// trigger
	trigger_detect trigger_i (
		.avalon_clk            (avalon_clk),
		.rst_n                 (rst_n),
		.rx_valid              (rx_valid),
		.samples               (rx_data),
		.triggering_status     (triggering_status),
		.triggering_time_stamp (triggering_time_stamp)
	);

	////////////////////////////// write path
	write_ctrl ctrl_i (
		.avalon_clk (avalon_clk),
		.rst_n      (rst_n),
		.bufs       (bufs),
		.load       (load),
		.sel        (sel),
		.accepted   (accepted)
	);

	dram_write_port port_i (
		.avalon_clk         (avalon_clk),
		.rst_n              (rst_n),
		.bufs               (bufs),
		.load               (load),
		.sel                (sel),
		.accepted           (accepted),
		.dram_wait_request  (dram_wait_request),
		.dram_write_address (dram_write_address),
		.dram_write_data    (dram_write_data),
		.dram_write_enable  (dram_write_enable)
	);

endmodule

/* dv/capture_tb.sv */
`timescale 1ns/1ps
/*
  replays dv/capture_trace.txt against capture_top, run from the project root
  expected lines are built from the samples driven here, in driving order
  trigger time and overflow mask come from the trace, writes from the line model
  a write order check assumes all channels stay in step, so no checks follow a drop
*/
module capture_tb import daq_pkg::*; ();

	localparam int clk_period = 40;           // ns
	localparam int lcg_seed   = 8;
	localparam int trace_len  = 512;          // five words per command
	localparam int ring_depth = 8;            // expected lines per channel

	logic                    avalon_clk = 1'b0;
	logic                    rst_n;
	logic                    rx_valid;
	sample_t                 rx_data [num_channels];
	logic                    dram_wait_request;
	logic [addr_w-1:0]       dram_write_address;
	line_t                   dram_write_data;
	logic                    dram_write_enable;
	logic                    triggering_status;
	logic [15:0]             triggering_time_stamp;
	logic [num_channels-1:0] overflow;

	logic [15:0]              trace_mem [trace_len];
	logic [31:0]              lcg_state;
	int                       word_idx;                       // next word slot of every line
	line_t                    part_line [num_channels];       // lines being packed
	line_t                    exp_ring [num_channels][ring_depth];
	int                       exp_wr [num_channels];
	int                       exp_rd [num_channels];
	int                       line_count [num_channels];      // expected counter per channel
	int                       next_ch;                        // round-robin expectation
	logic [addr_w+line_w-1:0] writes [$];                     // accepted writes, address on top
	int                       hi_len, lo_len, phase;          // wait request pattern
	int                       errors, checks;
	longint                   budget_cycles;
	logic                     stalled;                        // last edge saw enable and wait
	logic [addr_w-1:0]        held_addr;
	line_t                    held_data;

	capture_top dut_i (.*);

	always #(clk_period / 2) avalon_clk = ~avalon_clk;

	////////////////////////////// helpers
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic compare(input string name, input logic [line_w-1:0] exp_v,
			input logic [line_w-1:0] act_v);
		checks++;
		if (exp_v !== act_v) begin
			errors++;
			$display("Fail %s: expected %0h, actual %0h", name, exp_v, act_v);
		end
	endtask

	task automatic report_problem(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	// match every collected write against the line model
	task automatic check_writes();
		logic [addr_w+line_w-1:0] w;
		logic [addr_w-1:0]        addr;
		int                       ch;
		while (writes.size() > 0) begin
			w    = writes.pop_front();
			addr = w[addr_w+line_w-1:line_w];
			ch   = addr[addr_w-1 -: ch_w];                  // channel region
			compare("write channel order", next_ch, ch);
			next_ch = (next_ch + 1) % num_channels;         // channels in step, strict rotation
			if (exp_wr[ch] == exp_rd[ch]) begin
				report_problem($sformatf("write to channel %0d without a completed line", ch));
			end else begin
				compare($sformatf("ch%0d line data", ch),
					exp_ring[ch][exp_rd[ch] % ring_depth], w[line_w-1:0]);
				exp_rd[ch]++;
			end
			compare($sformatf("ch%0d line count", ch), line_count[ch], addr[line_cnt_w-1:0]);
			line_count[ch]++;
		end
	endtask

	// one cycle with inputs changed on the falling edge
	task automatic tick();
		@(negedge avalon_clk);
		dram_wait_request = (phase < hi_len);              // high for the first hi_len cycles
		phase = (hi_len + lo_len == 0) ? 0 : (phase + 1) % (hi_len + lo_len);
		check_writes();
	endtask

	task automatic strobe(input int gap, input int ovr_ch, input logic [15:0] ovr_val);
		int c;
		tick();
		rx_valid = 1'b1;
		for (c = 0; c < num_channels; c++) begin
			lcg_state  = lcg_next(lcg_state);
			rx_data[c] = (c == ovr_ch) ? ovr_val : {2'b00, lcg_state[29:16]}; // max 3fff
			part_line[c][word_idx*sample_w +: sample_w] = rx_data[c];   // sample 0 lowest
		end
		word_idx++;
		if (word_idx == words_per_line) begin
			for (c = 0; c < num_channels; c++) begin
				exp_ring[c][exp_wr[c] % ring_depth] = part_line[c];
				exp_wr[c]++;
			end
			word_idx = 0;
		end
		repeat (gap) begin
			tick();
			rx_valid = 1'b0;
		end
	endtask

	// wait until every completed line has been written
	task automatic drain();
		int   c;
		logic busy;
		busy = 1'b1;
		while (busy) begin
			tick();
			busy = 1'b0;
			for (c = 0; c < num_channels; c++) begin
				if (exp_wr[c] != exp_rd[c]) busy = 1'b1;
			end
		end
	endtask

	task automatic apply_reset();
		int c;
		rst_n    = 1'b0;
		rx_valid = 1'b0;
		repeat (3) tick();
		compare("write enable after reset", 1'b0, dram_write_enable);
		rst_n    = 1'b1;
		word_idx = 0;                                      // the DUT state is gone too
		next_ch  = 0;
		for (c = 0; c < num_channels; c++) begin
			exp_wr[c]     = 0;
			exp_rd[c]     = 0;
			line_count[c] = 0;
		end
	endtask

	// cycles of strobes, gaps, idles and resets in the trace
	function automatic longint trace_cycles();
		longint total;
		int     pc;
		total = 3;                                         // first reset
		pc    = 0;
		while (pc < trace_len && trace_mem[pc] !== 16'h000f) begin
			case (trace_mem[pc])
				16'h2:   total += trace_mem[pc+1] * (trace_mem[pc+2] + 1) + 1;
				16'h3:   total += trace_mem[pc+1];
				16'h7:   total += 3;
				default: ;
			endcase
			pc += 5;
		end
		return total;
	endfunction

	////////////////////////////// write monitor
	always @(posedge avalon_clk) begin
		if (!rst_n) begin
			stalled = 1'b0;
		end else begin
			if (stalled && dram_write_enable) begin              // must hold under wait request
				compare("stalled address", held_addr, dram_write_address);
				compare("stalled data", held_data, dram_write_data);
			end
			if (dram_write_enable && !dram_wait_request) begin
				writes.push_back({dram_write_address, dram_write_data});
			end
			stalled   = dram_write_enable && dram_wait_request;
			held_addr = dram_write_address;
			held_data = dram_write_data;
		end
	end

	////////////////////////////// watchdog
	initial begin
		wait (budget_cycles > 0);
		#(budget_cycles * clk_period * 4);
		$display("watchdog: run did not finish within %0d cycles", budget_cycles * 4);
		$display("SOME TESTS FAILED");
		$finish;
	end

	////////////////////////////// trace replay
	initial begin
		int          pc;
		int          c;
		logic [15:0] op, a, b, cc, d;
		rst_n             = 1'b0;
		rx_valid          = 1'b0;
		dram_wait_request = 1'b0;
		for (c = 0; c < num_channels; c++) rx_data[c] = '0;
		lcg_state = lcg_seed;
		hi_len    = 0;
		lo_len    = 1;                                      // wait request low
		phase     = 0;
		errors    = 0;
		checks    = 0;
		stalled   = 1'b0;
		$readmemh("dv/capture_trace.txt", trace_mem);
		budget_cycles = trace_cycles();
		apply_reset();
		pc = 0;
		while (pc < trace_len && trace_mem[pc] !== 16'h000f) begin
			op = trace_mem[pc];
			a  = trace_mem[pc+1];
			b  = trace_mem[pc+2];
			cc = trace_mem[pc+3];
			d  = trace_mem[pc+4];
			case (op)
				16'h1: begin
					hi_len = a;
					lo_len = b;
					phase  = 0;
				end
				16'h2: begin
					repeat (a) strobe(b, cc, d);
					tick();
					rx_valid = 1'b0;                        // last strobe is now registered
				end
				16'h3: repeat (a) tick();
				16'h4: drain();
				16'h5: begin
					compare("trigger status", a, triggering_status);
					compare("trigger time stamp", b, triggering_time_stamp);
				end
				16'h6: compare("overflow mask", a, overflow);
				16'h7: apply_reset();
				default: report_problem($sformatf("unknown trace command %0h at word %0d", op, pc));
			endcase
			pc += 5;
		end
		for (c = 0; c < num_channels; c++) begin
			if (exp_wr[c] != exp_rd[c]) begin
				report_problem($sformatf("channel %0d has lines that were never written", c));
			end
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* dv/capture_trace.txt */
// columns: op a b c d, hex, unused fields 0
// 1 wait hi lo | 2 send n gap ch val (ch 8 = no override) | 3 idle n | 4 drain
// 5 trigger status time | 6 overflow mask | 7 reset | f end
// packing, one line per channel
1 0 1 0 0
2 10 4 8 0
4 0 0 0 0
5 0 0 0 0
// round robin, two more lines per channel
2 20 1 8 0
4 0 0 0 0
// back-pressure, wait high 3 low 2
1 3 2 0 0
2 20 3 8 0
1 0 1 0 0
4 0 0 0 0
// long stall with a line parked in the write port
1 1 0 0 0
2 10 0 8 0
3 14 0 0 0
1 0 1 0 0
4 0 0 0 0
6 0 0 0 0
// overflow, wait high and a strobe every cycle
1 1 0 0 0
2 1f 0 8 0
6 0 0 0 0
2 11 0 8 0
6 ff 0 0 0
7 0 0 0 0
1 0 1 0 0
6 0 0 0 0
// trigger, index 5 at threshold, 6 above, 10 above again
2 5 1 8 0
5 0 0 0 0
2 1 1 3 7000
5 0 0 0 0
2 1 1 5 7001
5 1 6 0 0
2 3 1 8 0
2 1 1 0 ffff
5 1 6 0 0
2 5 1 8 0
4 0 0 0 0
f 0 0 0 0

/* files.f */
source/daq_pkg.sv
source/line_buffer_if.sv
source/channel_packer.sv
source/trigger_detect.sv
source/write_ctrl.sv
source/dram_write_port.sv
source/capture_top.sv
dv/capture_tb.sv

/* Bender.yml */
package:
  name: capture_frontend

sources:
  - source/daq_pkg.sv
  - source/line_buffer_if.sv
  - source/channel_packer.sv
  - source/trigger_detect.sv
  - source/write_ctrl.sv
  - source/dram_write_port.sv
  - source/capture_top.sv
  - target: test
    files:
      - dv/capture_tb.sv
